// ==== Bender.yml ====
package:
  name: cpu_backend

sources:
  - files:
      - cpu_pkg.sv
      - alu.sv
      - cmp.sv
      - ex_reg.sv
      - ex_stage.sv
      - mem_stage.sv
      - cpu_backend.sv
  - target: test
    files:
      - tb_cpu_backend.sv

// ==== alu.sv ====
/*
 * ALU
 * Combinational arithmetic, logic and shift unit of the execute stage.
 * Add and subtract are unsigned and wrap, shifts are logical and use
 * the low five bits of arg1. Unknown operation codes give zero.
 */
module alu (
    input  cpu_pkg::word_t   arg0,
    input  cpu_pkg::word_t   arg1,
    input  cpu_pkg::alu_op_e op,
    output cpu_pkg::word_t   val
);

    logic [4:0] shamt;  // Shift amount

    assign shamt = arg1[4:0];

    always_comb begin
        case (op)
            cpu_pkg::ALU_THA: begin
                val = arg0;                   // Pass through
            end
            cpu_pkg::ALU_ADDU: begin
                val = arg0 + arg1;
            end
            cpu_pkg::ALU_SUBU: begin
                val = arg0 - arg1;
            end
            cpu_pkg::ALU_AND:  val = arg0 & arg1;
            cpu_pkg::ALU_OR:   val = arg0 | arg1;
            cpu_pkg::ALU_XOR:  val = arg0 ^ arg1;
            cpu_pkg::ALU_SHRL: begin
                val = arg0 >> shamt;          // Zero fill from the top
            end
            cpu_pkg::ALU_SHLL: begin
                val = arg0 << shamt;
            end
            default: begin
                val = '0;                     // Undefined op
            end
        endcase
    end

endmodule

// ==== backend_stimulus.txt ====
# Columns, all hex: flush en alu_op alu_in_0 alu_in_1 cmp_op cmp_in_0 cmp_in_1 mem_op
# mem_wr_data dst_addr gpr_we_n out_sel gpr_wr_data ra_addr rb_addr jump_taken
# then expected br_taken br_addr wb_valid wb_dst_addr wb_data; first data line is the count
32
0 1 1 1234 f00 0 0 0 0 0 1 0 0 0 0 0 0 0 2134 1 1 2134
0 1 2 5 7 1 11 11 0 0 2 0 0 0 0 0 0 1 fffffffe 1 2 fffffffe
0 1 3 f0f0f0f0 ff00ff00 2 3 3 0 0 3 0 0 0 0 0 0 0 f000f000 1 3 f000f000
0 1 4 f0f0f0f0 0f0000ff 2 3 4 0 0 4 0 0 0 0 0 0 1 fff0f0ff 1 4 fff0f0ff
0 1 5 aaaa5555 ffff0000 3 ffffffff 1 0 0 5 0 0 0 0 0 0 1 55555555 1 5 55555555
0 1 6 80000000 24 4 ffffffff 1 0 0 6 0 0 0 0 0 0 0 08000000 1 6 08000000
0 1 7 3 ffffffe8 5 80000000 7fffffff 0 0 7 0 0 0 0 0 0 0 300 1 7 300
0 1 0 deadbeef 12345678 5 7fffffff 80000000 0 0 8 0 0 0 0 0 0 1 deadbeef 1 8 deadbeef
0 1 1 ffffffff 1 3 5 fffffffb 0 0 9 0 0 0 0 0 0 0 0 1 9 0
0 1 6 ffffffff 1f 4 5 fffffffb 0 0 a 0 0 0 0 0 0 1 1 1 a 1
0 1 7 1 1f 5 7 7 0 0 b 0 0 0 0 0 0 1 80000000 1 b 80000000
0 1 1 1000 40 0 0 0 0 0 1f 0 1 104 0 0 1 1 1040 1 1f 104
0 1 1 5 6 1 1 2 0 0 c 0 2 0 0 0 0 0 b 1 c 0
0 1 1 100 10 0 0 0 2 cafef00d 0 1 0 0 0 0 0 0 110 0 0 0
0 1 1 200 4 0 0 0 2 13572468 0 1 0 0 0 0 0 0 204 0 0 0
0 1 1 100 10 0 0 0 1 0 d 0 0 0 0 0 0 0 110 1 d cafef00d
0 1 1 0 1 0 0 0 0 0 e 0 0 0 d 0 0 0 cafef00e 1 e cafef00e
0 1 1 200 4 0 0 0 1 0 f 0 0 0 0 0 0 0 204 1 f 13572468
0 1 1 300 8 0 0 0 2 0 0 1 0 0 0 f 0 0 308 0 0 0
0 1 1 300 8 0 0 0 1 0 10 0 0 0 0 0 0 0 308 1 10 13572468
0 1 1 100 10 0 0 0 1 0 0 0 0 0 0 0 0 0 110 1 0 cafef00d
0 1 0 777 0 0 0 0 0 0 11 0 0 0 0 0 0 0 777 1 11 777
0 1 0 55 0 0 0 0 0 0 12 0 0 0 11 0 0 0 55 1 12 55
1 1 1 100 10 0 0 0 2 badbad00 0 1 0 0 0 0 0 0 110 0 0 0
1 1 1 1 2 0 0 0 0 0 13 0 0 0 0 0 0 0 3 0 0 0
0 1 1 100 10 0 0 0 1 0 14 0 0 0 0 0 0 0 110 1 14 cafef00d
1 1 1 200 4 0 0 0 1 0 15 0 0 0 0 0 0 0 204 0 0 0
0 1 1 10 1 0 0 0 0 0 16 0 0 0 15 0 0 0 11 1 16 11
0 0 1 20 20 2 1 2 0 0 17 0 0 0 0 0 0 1 40 0 0 0
0 0 1 200 4 0 0 0 2 ffffffff 0 1 0 0 0 0 0 0 204 0 0 0
0 1 1 200 4 0 0 0 1 0 18 0 0 0 0 0 0 0 204 1 18 13572468
0 1 5 12345678 ffffffff 5 ffffffff 0 0 0 19 0 0 0 0 0 0 0 edcba987 1 19 edcba987

// ==== cmp.sv ====
/*
 * Branch comparator
 * Compares two words for the branch unit, signed or unsigned as the
 * operation asks. NONE and undefined codes never give true.
 */
module cmp (
    input  cpu_pkg::word_t   arg0,
    input  cpu_pkg::word_t   arg1,
    input  cpu_pkg::cmp_op_e op,
    output logic             true
);

    logic eq;      // Equal
    logic lt_s;    // Less than, signed
    logic lt_u;    // Less than, unsigned

    assign eq   = (arg0 == arg1);
    assign lt_s = ($signed(arg0) < $signed(arg1));
    assign lt_u = (arg0 < arg1);

    always_comb begin
        case (op)
            cpu_pkg::CMP_EQ:  true = eq;
            cpu_pkg::CMP_NE:  true = ~eq;
            cpu_pkg::CMP_LT:  true = lt_s;
            cpu_pkg::CMP_LTU: true = lt_u;
            cpu_pkg::CMP_GE:  true = ~lt_s;  // Signed greater or equal
            default:          true = 1'b0;   // NONE and unknown
        endcase
    end

endmodule

// ==== cpu_backend.sv ====
/*
 * CPU back end top
 * Execute stage followed by the memory stage. Takes a decoded
 * instruction, returns the writeback bundle two cycles later and
 * the branch outputs in the same cycle.
 */
module cpu_backend (
    input  logic             clk,
    input  logic             arst_n,
    // Pipeline control levels
    input  logic             stall,
    input  logic             flush,
    // Decoded instruction
    input  cpu_pkg::id_ex_t  id,
    // Writeback bundle
    output cpu_pkg::mem_wb_t wb,
    // Branch outputs
    output cpu_pkg::word_t   br_addr,
    output logic             br_taken
);

    cpu_pkg::ex_mem_t ex_mem;        // EX to MEM
    cpu_pkg::word_t   mem_fwd_data;  // MEM back to EX, load result

    ex_stage ex_stage_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .stall        (stall),
        .flush        (flush),
        .id           (id),
        .mem_fwd_data (mem_fwd_data),
        .ex_mem       (ex_mem),
        .br_addr      (br_addr),
        .br_taken     (br_taken)
    );

    mem_stage mem_stage_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .stall        (stall),
        .ex_mem       (ex_mem),
        .mem_fwd_data (mem_fwd_data),
        .wb           (wb)
    );

endmodule

// ==== cpu_pkg.sv ====
/*
 * CPU back end package
 * Shared widths, word types, operation codes, output selects and the
 * pipeline bundles that travel between the execute and memory stages.
 * Also holds the reset/bubble values of the pipeline registers.
 */
package cpu_pkg;

    localparam int WORD_W     = 32;   // Data and address width
    localparam int DMEM_DEPTH = 256;  // Data memory size in words

    typedef logic [WORD_W-1:0]             word_t;       // Data / address word
    typedef logic [4:0]                    reg_addr_t;   // GPR number
    typedef logic [$clog2(DMEM_DEPTH)-1:0] dmem_addr_t;  // Word index into data memory

    // ALU operations, shifts take arg1[4:0]
    typedef enum logic [3:0] {
        ALU_THA  = 4'd0,  // Pass arg0
        ALU_ADDU = 4'd1,
        ALU_SUBU = 4'd2,
        ALU_AND  = 4'd3,
        ALU_OR   = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SHRL = 4'd6,  // Logical right
        ALU_SHLL = 4'd7   // Logical left
    } alu_op_e;

    // Branch compare operations
    typedef enum logic [2:0] {
        CMP_NONE = 3'd0,  // Never true
        CMP_EQ   = 3'd1,
        CMP_NE   = 3'd2,
        CMP_LT   = 3'd3,  // Signed
        CMP_LTU  = 3'd4,
        CMP_GE   = 3'd5   // Signed
    } cmp_op_e;

    typedef enum logic [1:0] {
        MEM_NOP = 2'd0,
        MEM_LDW = 2'd1,   // Load word
        MEM_STW = 2'd2    // Store word
    } mem_op_e;

    // Source of the EX stage result
    typedef enum logic [1:0] {
        OUT_ALU  = 2'd0,
        OUT_PCN  = 2'd1,  // Return address from decode
        OUT_ZERO = 2'd2
    } ex_out_sel_e;

    // Decoded instruction entering EX
    typedef struct packed {
        logic        en;
        alu_op_e     alu_op;
        word_t       alu_in_0;
        word_t       alu_in_1;     // Immediate for loads and stores
        cmp_op_e     cmp_op;
        word_t       cmp_in_0;
        word_t       cmp_in_1;
        mem_op_e     mem_op;
        word_t       mem_wr_data;
        reg_addr_t   dst_addr;
        logic        gpr_we_n;     // Active low write enable
        ex_out_sel_e out_sel;
        word_t       gpr_wr_data;  // PC + 4 for PCN
        reg_addr_t   ra_addr;
        reg_addr_t   rb_addr;
        logic        jump_taken;
    } id_ex_t;

    // EX/MEM register contents
    typedef struct packed {
        logic      en;
        mem_op_e   mem_op;
        word_t     mem_wr_data;
        reg_addr_t dst_addr;
        logic      gpr_we_n;
        word_t     ex_out;     // Result or memory address
    } ex_mem_t;

    // MEM/WB register contents, the writeback bundle
    typedef struct packed {
        logic      en;
        reg_addr_t dst_addr;
        logic      gpr_we_n;
        word_t     data;
    } mem_wb_t;

    // Bubbles loaded on reset and flush
    localparam ex_mem_t EX_MEM_BUBBLE = '{en: 1'b0, mem_op: MEM_NOP, mem_wr_data: '0,
                                         dst_addr: '0, gpr_we_n: 1'b1, ex_out: '0};
    localparam mem_wb_t MEM_WB_BUBBLE = '{en: 1'b0, dst_addr: '0, gpr_we_n: 1'b1,
                                         data: '0};

endpackage

// ==== ex_reg.sv ====
/*
 * EX/MEM pipeline register
 * Holds on stall, takes a bubble on flush and otherwise captures the
 * bundle built by the execute stage. Reset clears it to a bubble.
 */
module ex_reg (
    input  logic             clk,
    input  logic             arst_n,
    // Pipeline control
    input  logic             stall,
    input  logic             flush,
    // Next and current EX/MEM contents
    input  cpu_pkg::ex_mem_t d,
    output cpu_pkg::ex_mem_t q
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= cpu_pkg::EX_MEM_BUBBLE;        // Empty pipeline after reset
        end else if (!stall) begin
            if (flush) begin
                q <= cpu_pkg::EX_MEM_BUBBLE;    // Drop the instruction in EX
            end else begin
                q <= d;
            end
        end
        // Stall keeps q as is
    end

endmodule

// ==== ex_stage.sv ====
/*
 * Execute stage
 * Forwards load data from MEM into the operands, runs the ALU and the
 * branch comparator, selects the stage result and drives the branch
 * target and taken flag. The result bundle goes into the EX/MEM
 * register.
 */
module ex_stage (
    input  logic             clk,
    input  logic             arst_n,
    // Pipeline control
    input  logic             stall,
    input  logic             flush,
    // Decoded instruction
    input  cpu_pkg::id_ex_t  id,
    // Load result of the instruction in MEM
    input  cpu_pkg::word_t   mem_fwd_data,
    // EX/MEM register
    output cpu_pkg::ex_mem_t ex_mem,
    // Branch outputs, combinational
    output cpu_pkg::word_t   br_addr,
    output logic             br_taken
);

    logic             load_in_mem;   // EX/MEM holds a load writing a real GPR
    logic             ra_fwd_en;
    logic             rb_fwd_en;
    cpu_pkg::word_t   alu_in_0;      // Operand after forwarding
    cpu_pkg::word_t   mem_wr_data;   // Store data after forwarding
    cpu_pkg::word_t   alu_out;
    logic             cmp_out;
    cpu_pkg::word_t   ex_out;
    cpu_pkg::ex_mem_t ex_mem_next;

    // Load-use forwarding from the instruction one stage ahead
    assign load_in_mem = ex_mem.en && (ex_mem.mem_op == cpu_pkg::MEM_LDW)
                         && !ex_mem.gpr_we_n && (ex_mem.dst_addr != '0);  // r0 never forwards
    assign ra_fwd_en   = load_in_mem && (ex_mem.dst_addr == id.ra_addr);
    assign rb_fwd_en   = load_in_mem && (ex_mem.dst_addr == id.rb_addr);

    assign alu_in_0    = ra_fwd_en ? mem_fwd_data : id.alu_in_0;
    assign mem_wr_data = rb_fwd_en ? mem_fwd_data : id.mem_wr_data;  // Load then store
    // alu_in_1 holds the immediate on a store, so it is never replaced

    alu alu_i (
        .arg0 (alu_in_0),
        .arg1 (id.alu_in_1),
        .op   (id.alu_op),
        .val  (alu_out)
    );

    cmp cmp_i (
        .arg0 (id.cmp_in_0),
        .arg1 (id.cmp_in_1),
        .op   (id.cmp_op),
        .true (cmp_out)
    );

    // Stage result select
    always_comb begin
        case (id.out_sel)
            cpu_pkg::OUT_ALU: begin
                ex_out = alu_out;
            end
            cpu_pkg::OUT_PCN: begin
                ex_out = id.gpr_wr_data;  // Link value
            end
            default: begin
                ex_out = '0;              // ZERO and unknown
            end
        endcase
    end

    // Target comes from the ALU, taken from compare or an unconditional jump
    assign br_addr  = alu_out;
    assign br_taken = cmp_out | id.jump_taken;

    // Pack the next EX/MEM bundle
    always_comb begin
        ex_mem_next.en          = id.en;
        ex_mem_next.mem_op      = id.mem_op;
        ex_mem_next.mem_wr_data = mem_wr_data;
        ex_mem_next.dst_addr    = id.dst_addr;
        ex_mem_next.gpr_we_n    = id.gpr_we_n;
        ex_mem_next.ex_out      = ex_out;     // Address for loads and stores
    end

    ex_reg ex_reg_i (
        .clk    (clk),
        .arst_n (arst_n),
        .stall  (stall),
        .flush  (flush),
        .d      (ex_mem_next),
        .q      (ex_mem)
    );

endmodule

// ==== mem_stage.sv ====
/*
 * Memory access stage
 * Word-addressed data memory with combinational read and clocked write,
 * plus the MEM/WB register. The load result, or the EX result for other
 * operations, goes both back to EX for forwarding and into writeback.
 */
module mem_stage (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             stall,
    // EX/MEM register contents
    input  cpu_pkg::ex_mem_t ex_mem,
    // Result of the instruction now in MEM
    output cpu_pkg::word_t   mem_fwd_data,
    // MEM/WB register
    output cpu_pkg::mem_wb_t wb
);

    cpu_pkg::word_t     dmem [cpu_pkg::DMEM_DEPTH];  // Data memory, no reset
    cpu_pkg::dmem_addr_t dmem_addr;
    cpu_pkg::word_t     load_data;
    cpu_pkg::word_t     mem_out;
    logic               is_load;
    logic               do_store;
    cpu_pkg::mem_wb_t   wb_next;

    // Byte address to word index
    assign dmem_addr = ex_mem.ex_out[9:2];

    assign is_load   = (ex_mem.mem_op == cpu_pkg::MEM_LDW);
    assign do_store  = ex_mem.en && (ex_mem.mem_op == cpu_pkg::MEM_STW)
                       && !stall;  // Frozen pipeline writes nothing

    // Asynchronous read
    assign load_data = dmem[dmem_addr];

    // Store at the clock edge
    always_ff @(posedge clk) begin
        if (do_store) begin
            dmem[dmem_addr] <= ex_mem.mem_wr_data;
        end
    end

    // Loads return memory data, everything else passes the EX result
    assign mem_out      = is_load ? load_data : ex_mem.ex_out;
    assign mem_fwd_data = mem_out;

    always_comb begin
        wb_next.en       = ex_mem.en;
        wb_next.dst_addr = ex_mem.dst_addr;
        wb_next.gpr_we_n = ex_mem.gpr_we_n;
        wb_next.data     = mem_out;
    end

    // MEM/WB register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb <= cpu_pkg::MEM_WB_BUBBLE;
        end else if (!stall) begin
            wb <= wb_next;  // Flush does not stop this stage
        end
    end

endmodule

// ==== tb.f ====
cpu_pkg.sv
alu.sv
cmp.sv
ex_reg.sv
ex_stage.sv
mem_stage.sv
cpu_backend.sv
tb_cpu_backend.sv

// ==== tb_cpu_backend.sv ====
/*
 * Testbench for the CPU back end
 * Reads instruction vectors and their expected results, drives them into
 * the DUT with random stall cycles, checks the branch outputs every cycle
 * and the writeback bundles in issue order.
 */
module tb_cpu_backend;

    timeunit 1ns;
    timeprecision 1ps;

    // One vector of the stimulus file
    typedef struct packed {
        logic               flush;
        cpu_pkg::id_ex_t    id;
        logic               br_taken;   // Expected branch outputs
        cpu_pkg::word_t     br_addr;
        logic               wb;         // Writeback expected
        cpu_pkg::reg_addr_t dst_addr;
        cpu_pkg::word_t     data;
    } vector_t;

    // Writeback still in flight
    typedef struct packed {
        int                 idx;        // Vector number used in messages
        cpu_pkg::reg_addr_t dst_addr;
        cpu_pkg::word_t     data;
    } wb_exp_t;

    logic             clk;
    logic             arst_n;
    logic             stall;
    logic             flush;
    cpu_pkg::id_ex_t  id;
    cpu_pkg::mem_wb_t wb;
    cpu_pkg::word_t   br_addr;
    logic             br_taken;

    vector_t vectors [$];
    wb_exp_t wb_pending [$];            // Oldest first
    integer  seed = 87004;
    int      value_errs = 0;
    int      other_errs = 0;
    int      cycle_cnt = 0;
    int      cycle_limit = 0;           // Zero until the vectors are read
    bit      load_ok;

    cpu_backend i_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .stall    (stall),
        .flush    (flush),
        .id       (id),
        .wb       (wb),
        .br_addr  (br_addr),
        .br_taken (br_taken)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;          // 4 ns period
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout, the run did not end within %0d cycles", cycle_limit);
            $display("Errors: %0d value mismatches, %0d other failures",
                     value_errs, other_errs + 1);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Empty instruction that writes no register
    function automatic cpu_pkg::id_ex_t idle_bundle();
        cpu_pkg::id_ex_t b;
        b          = '0;
        b.gpr_we_n = 1'b1;
        return b;
    endfunction

    task automatic read_vectors(output bit ok);
        int          fd;
        int          n_vec;
        int          got;
        string       line;
        logic [31:0] col [22];
        vector_t     v;
        ok    = 1'b0;
        n_vec = -1;
        fd    = $fopen("backend_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open backend_stimulus.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;               // Comment or blank line
            end
            if (n_vec < 0) begin
                got = $sscanf(line, "%d", n_vec);   // Count line
                continue;
            end
            got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                          col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                          col[15], col[16], col[17], col[18], col[19], col[20], col[21]);
            if (got != 22) begin
                $display("Vector %0d in the stimulus file is malformed", vectors.size() + 1);
                $fclose(fd);
                return;
            end
            v.flush          = col[0][0];
            v.id.en          = col[1][0];
            v.id.alu_op      = cpu_pkg::alu_op_e'(col[2][3:0]);
            v.id.alu_in_0    = col[3];
            v.id.alu_in_1    = col[4];
            v.id.cmp_op      = cpu_pkg::cmp_op_e'(col[5][2:0]);
            v.id.cmp_in_0    = col[6];
            v.id.cmp_in_1    = col[7];
            v.id.mem_op      = cpu_pkg::mem_op_e'(col[8][1:0]);
            v.id.mem_wr_data = col[9];
            v.id.dst_addr    = col[10][4:0];
            v.id.gpr_we_n    = col[11][0];
            v.id.out_sel     = cpu_pkg::ex_out_sel_e'(col[12][1:0]);
            v.id.gpr_wr_data = col[13];
            v.id.ra_addr     = col[14][4:0];
            v.id.rb_addr     = col[15][4:0];
            v.id.jump_taken  = col[16][0];
            v.br_taken       = col[17][0];
            v.br_addr        = col[18];
            v.wb             = col[19][0];
            v.dst_addr       = col[20][4:0];
            v.data           = col[21];
            vectors.push_back(v);
        end
        $fclose(fd);
        if (n_vec <= 0 || vectors.size() != n_vec) begin
            $display("Stimulus file holds %0d vectors but its count line says %0d",
                     vectors.size(), n_vec);
            return;
        end
        ok = 1'b1;
    endtask

    task automatic check_branch(input vector_t v, input int idx);
        if (br_taken !== v.br_taken) begin
            value_errs++;
            $display("CHECK FAILED: br_taken vector %0d got %h expected %h",
                     idx, br_taken, v.br_taken);
        end
        if (br_addr !== v.br_addr) begin
            value_errs++;
            $display("CHECK FAILED: br_addr vector %0d got %h expected %h",
                     idx, br_addr, v.br_addr);
        end
    endtask

    // Loaded tells whether MEM/WB took a new bundle at the last edge
    task automatic check_writeback(input bit loaded);
        wb_exp_t e;
        if (loaded && wb.en === 1'b1 && wb.gpr_we_n === 1'b0) begin
            if (wb_pending.size() == 0) begin
                other_errs++;
                $display("Unexpected writeback to register %0d with data %h",
                         wb.dst_addr, wb.data);
            end else begin
                e = wb_pending.pop_front();
                if (wb.dst_addr !== e.dst_addr) begin
                    value_errs++;
                    $display("CHECK FAILED: wb.dst_addr vector %0d got %h expected %h",
                             e.idx, wb.dst_addr, e.dst_addr);
                end
                if (wb.data !== e.data) begin
                    value_errs++;
                    $display("CHECK FAILED: wb.data vector %0d got %h expected %h",
                             e.idx, wb.data, e.data);
                end
            end
        end
    endtask

    // One cycle with the vector on the inputs and stall driven from hold
    task automatic present_vector(input vector_t v, input int idx, input logic hold);
        bit      loaded;
        wb_exp_t e;
        @(posedge clk);
        loaded = !stall;                // Stall level the DUT sees at this edge
        id    <= v.id;
        flush <= v.flush;
        stall <= hold;
        @(negedge clk);                 // Outputs settled
        check_writeback(loaded);
        check_branch(v, idx);
        if (!hold && !v.flush && v.id.en && v.wb) begin
            e.idx      = idx;
            e.dst_addr = v.dst_addr;
            e.data     = v.data;
            wb_pending.push_back(e);    // Accepted at the coming edge
        end
    endtask

    task automatic drive_idle();
        bit loaded;
        @(posedge clk);
        loaded = !stall;
        id    <= idle_bundle();
        flush <= 1'b0;
        stall <= 1'b0;
        @(negedge clk);
        check_writeback(loaded);
    endtask

    initial begin
        int n_stall;
        arst_n = 1'b0;
        stall  = 1'b0;
        flush  = 1'b0;
        id     = idle_bundle();
        read_vectors(load_ok);
        if (!load_ok) begin
            other_errs++;
        end else begin
            cycle_limit = 4 * vectors.size() + 100;
            repeat (16) @(posedge clk);
            arst_n <= 1'b1;
            foreach (vectors[i]) begin
                n_stall = $unsigned($random(seed)) % 3;    // Zero to two stall cycles
                repeat (n_stall) present_vector(vectors[i], i + 1, 1'b1);
                present_vector(vectors[i], i + 1, 1'b0);
            end
            repeat (4) drive_idle();    // Drain both stages
            if (wb_pending.size() != 0) begin
                other_errs++;
                $display("%0d expected writebacks never appeared", wb_pending.size());
            end
        end
        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
